// File: include/flow_defs.svh
/* widths and depths of the flow table controller
   the exact index must stay 8 bits wide, it is built from XORed key bytes */
`ifndef FLOW_DEFS_SVH
`define FLOW_DEFS_SVH

// ----------------------------------------
// requesters
// ----------------------------------------
// lookup ports, the host is one more requester on top
`define FLOW_NUM_PORTS 4

// ----------------------------------------
// data widths
// ----------------------------------------
`define FLOW_MATCH_W 64
`define FLOW_ACTION_W 32
`define FLOW_CNT_W 32

// ----------------------------------------
// tables
// ----------------------------------------
`define FLOW_EX_IDX_W 8
`define FLOW_WC_DEPTH 8
`define FLOW_WC_IDX_W 3

// cycles from ack to done
`define FLOW_LATENCY 4

`endif

// File: sim.f
+incdir+include
src/flow_pkg.sv
src/flow_arbiter.sv
src/flow_hash.sv
src/exact_table.sv
src/wildcard_table.sv
src/action_select.sv
src/flow_table_ctrl.sv
sim/flow_table_props.sv
sim/flow_table_tb.sv

// File: sim/flow_table_props.sv
/* bound into flow_table_ctrl, ack one-hot, no back-to-back grant, done after 4 cycles
   a requester holding req must see its ack within 5 cycles */
`timescale 1ns/1ns
`include "flow_defs.svh"

module flow_table_props (
   input logic asclk,
   input logic aresetn,
   input logic [`FLOW_NUM_PORTS-1:0] port_req,
   input logic host_req,
   input logic [`FLOW_NUM_PORTS-1:0] port_ack,
   input logic host_ack,
   input logic [`FLOW_NUM_PORTS-1:0] port_done,
   input logic host_done
);

   localparam int NUM_REQ = `FLOW_NUM_PORTS + 1;

   logic [NUM_REQ-1:0] req_all;
   logic [NUM_REQ-1:0] ack_all;
   logic [NUM_REQ-1:0] done_all;
   int fail_count = 0;

   assign req_all = {host_req, port_req};
   assign ack_all = {host_ack, port_ack};
   assign done_all = {host_done, port_done};

   a_onehot: assert property (@(posedge asclk) disable iff (!aresetn) $onehot0(ack_all))
      else begin
         $error("more than one ack in a cycle");
         fail_count++;
      end

   a_no_repeat: assert property (@(posedge asclk) disable iff (!aresetn)
      (ack_all & $past(ack_all)) == '0)
      else begin
         $error("requester acked in two consecutive cycles");
         fail_count++;
      end

   // every done, port or host, mirrors an ack four cycles back
   a_latency: assert property (@(posedge asclk) disable iff (!aresetn)
      done_all == $past(ack_all, `FLOW_LATENCY))
      else begin
         $error("done does not follow its ack by the pipeline latency");
         fail_count++;
      end

   // ----------------------------------------
   // wait bound per requester
   // ----------------------------------------
   for (genvar i = 0; i < NUM_REQ; i++) begin : g_wait
      logic [2:0] wait_cnt;

      always_ff @(posedge asclk) begin
         if (!aresetn) begin
            wait_cnt <= '0;
         end else if (ack_all[i] || !req_all[i]) begin
            wait_cnt <= '0;
         end else begin
            wait_cnt <= wait_cnt + 1'b1;
         end
      end

      a_wait: assert property (@(posedge asclk) disable iff (!aresetn) wait_cnt <= 3'd5)
         else begin
            $error("requester %0d waited more than 5 cycles for ack", i);
            fail_count++;
         end
   end

endmodule

bind flow_table_ctrl flow_table_props u_props (
   .asclk(asclk),
   .aresetn(aresetn),
   .port_req(port_req),
   .host_req(host_req),
   .port_ack(port_ack),
   .host_ack(host_ack),
   .port_done(port_done),
   .host_done(host_done)
);

// File: sim/flow_table_tb.sv
/* testbench for flow_table_ctrl, keeps its own copy of both tables
   lookups start only after earlier host writes have completed */
`timescale 1ns/1ns
`include "flow_defs.svh"

module flow_table_tb;

   localparam int CLK_PERIOD = 20;
   localparam int RESET_CYCLES = 16;
   localparam int NP = `FLOW_NUM_PORTS;
   localparam int EX_DEPTH = 1 << `FLOW_EX_IDX_W;
   localparam int BURST = 6;
   // 5 writes, 7 single lookups, then one burst per requester
   localparam int NUM_OPS = 5 + 7 + BURST * (NP + 1);
   localparam int OP_CYCLES = 12;
   localparam int WATCHDOG_NS = (RESET_CYCLES + NUM_OPS * OP_CYCLES + 200) * CLK_PERIOD;

   typedef struct packed {
      logic ex_hit;
      logic wc_hit;
      flow_pkg::action_t action;
   } expect_t;

   logic asclk = 1'b0;
   logic aresetn;
   logic [NP-1:0] port_req;
   flow_pkg::match_t port_match [NP];
   logic [NP-1:0] port_ack;
   logic [NP-1:0] port_done;
   flow_pkg::action_t action_out;
   logic host_req;
   logic host_wc;
   flow_pkg::ex_idx_t host_addr;
   flow_pkg::match_t host_match;
   flow_pkg::match_t host_mask;
   flow_pkg::action_t host_action;
   logic host_ack;
   logic host_done;
   flow_pkg::cnt_t exact_hit;
   flow_pkg::cnt_t exact_miss;
   flow_pkg::cnt_t wildcard_hit;
   flow_pkg::cnt_t wildcard_miss;
   flow_pkg::cnt_t port_dropped [NP];

   // table copy
   flow_pkg::match_t ex_key [EX_DEPTH];
   flow_pkg::action_t ex_act [EX_DEPTH];
   logic [EX_DEPTH-1:0] ex_valid;
   flow_pkg::match_t wc_key [`FLOW_WC_DEPTH];
   flow_pkg::match_t wc_mask [`FLOW_WC_DEPTH];
   flow_pkg::action_t wc_act [`FLOW_WC_DEPTH];
   logic [`FLOW_WC_DEPTH-1:0] wc_valid;

   // expected results and counters
   expect_t exp_q [NP][$];
   flow_pkg::cnt_t m_ex_hit;
   flow_pkg::cnt_t m_ex_miss;
   flow_pkg::cnt_t m_wc_hit;
   flow_pkg::cnt_t m_wc_miss;
   flow_pkg::cnt_t m_drop [NP];
   flow_pkg::match_t key_set [8];
   int host_pend = 0;
   int errors = 0;
   int tests = 0;
   int failed_tests = 0;
   integer seed = 13456;

   flow_table_ctrl u_flow_table_ctrl (.*);

   always #(CLK_PERIOD / 2) asclk = ~asclk;

   initial begin
      #(WATCHDOG_NS);
      $display("watchdog expired, the run did not finish within %0d ns", WATCHDOG_NS);
      $display("=== FAIL ===");
      $finish;
   end

   // ----------------------------------------
   // reference rules
   // ----------------------------------------
   function automatic flow_pkg::ex_idx_t fold_bytes(flow_pkg::match_t key, bit rotate);
      logic [7:0] b;
      flow_pkg::ex_idx_t acc;
      acc = '0;
      for (int k = 0; k < 8; k++) begin
         b = key[8*k +: 8];
         if (rotate && k != 0) begin
            b = (b << k) | (b >> (8 - k));
         end
         acc = acc ^ b;
      end
      return acc;
   endfunction

   function automatic expect_t predict(flow_pkg::match_t key);
      expect_t e;
      flow_pkg::ex_idx_t i0;
      flow_pkg::ex_idx_t i1;
      flow_pkg::action_t wc_a;
      e = '0;
      wc_a = '0;
      i0 = fold_bytes(key, 1'b0);
      i1 = fold_bytes(key, 1'b1);
      if (ex_valid[i0] && ex_key[i0] == key) begin
         e.ex_hit = 1'b1;
         e.action = ex_act[i0];
      end else if (ex_valid[i1] && ex_key[i1] == key) begin
         e.ex_hit = 1'b1;
         e.action = ex_act[i1];
      end
      for (int i = 0; i < `FLOW_WC_DEPTH; i++) begin
         if (!e.wc_hit && wc_valid[i] && ((key ^ wc_key[i]) & ~wc_mask[i]) == '0) begin
            e.wc_hit = 1'b1;
            wc_a = wc_act[i];
         end
      end
      if (!e.ex_hit && e.wc_hit) begin
         e.action = wc_a;
      end
      return e;
   endfunction

   function automatic flow_pkg::match_t random_key();
      return {$random(seed), $random(seed)};
   endfunction

   function automatic bit work_pending();
      bit busy;
      busy = (host_pend != 0);
      for (int p = 0; p < NP; p++) begin
         busy = busy || (exp_q[p].size() != 0);
      end
      return busy;
   endfunction

   task automatic note_error(input string msg);
      $display("error %0t: %s", $time, msg);
      errors++;
   endtask

   task automatic finish_test(input string name, input int mark);
      tests++;
      if (errors == mark) begin
         $display("test %s: ok", name);
      end else begin
         $display("test %s: failed with %0d errors", name, errors - mark);
         failed_tests++;
      end
   endtask

   // ----------------------------------------
   // drivers, called on a falling edge
   // ----------------------------------------
   task automatic host_write(input logic wc, input flow_pkg::ex_idx_t addr,
                             input flow_pkg::match_t key, input flow_pkg::match_t mask,
                             input flow_pkg::action_t act);
      int lat;
      if (wc) begin
         wc_key[addr[`FLOW_WC_IDX_W-1:0]] = key;
         wc_mask[addr[`FLOW_WC_IDX_W-1:0]] = mask;
         wc_act[addr[`FLOW_WC_IDX_W-1:0]] = act;
         wc_valid[addr[`FLOW_WC_IDX_W-1:0]] = 1'b1;
      end else begin
         ex_key[addr] = key;
         ex_act[addr] = act;
         ex_valid[addr] = 1'b1;
      end
      host_wc = wc;
      host_addr = addr;
      host_match = key;
      host_mask = mask;
      host_action = act;
      host_req = 1'b1;
      do @(negedge asclk); while (!host_ack);
      host_req = 1'b0;
      lat = 0;
      while (!host_done) begin
         @(negedge asclk);
         lat++;
      end
      assert (lat == `FLOW_LATENCY)
         else note_error($sformatf("host_done %0d cycles after host_ack", lat));
   endtask

   task automatic lookup(input int p, input flow_pkg::match_t key);
      int lat;
      exp_q[p].push_back(predict(key));
      port_match[p] = key;
      port_req[p] = 1'b1;
      do @(negedge asclk); while (!port_ack[p]);
      port_req[p] = 1'b0;
      lat = 0;
      while (!port_done[p]) begin
         @(negedge asclk);
         lat++;
      end
      assert (lat == `FLOW_LATENCY)
         else note_error($sformatf("port %0d done %0d cycles after ack", p, lat));
   endtask

   // req stays high from one request to the next
   task automatic lookup_burst(input int p, input int n);
      flow_pkg::match_t key;
      for (int i = 0; i < n; i++) begin
         key = key_set[$unsigned($random(seed)) % 8];
         exp_q[p].push_back(predict(key));
         port_match[p] = key;
         port_req[p] = 1'b1;
         do @(negedge asclk); while (!port_ack[p]);
      end
      port_req[p] = 1'b0;
   endtask

   // rewrites wildcard entry 5 with its own contents
   task automatic host_rewrite_burst(input int n);
      for (int i = 0; i < n; i++) begin
         host_wc = 1'b1;
         host_addr = 8'd5;
         host_match = wc_key[5];
         host_mask = wc_mask[5];
         host_action = wc_act[5];
         host_req = 1'b1;
         do @(negedge asclk); while (!host_ack);
      end
      host_req = 1'b0;
   endtask

   // ----------------------------------------
   // done monitor
   // ----------------------------------------
   always @(negedge asclk) begin : monitor
      expect_t e;
      if (aresetn) begin
         if (host_done) begin
            assert (host_pend > 0) else begin
               $display("host_done pulsed with no host write in flight at %0t", $time);
               errors++;
            end
            host_pend--;
         end
         if (host_ack) begin
            host_pend++;
         end
         for (int p = 0; p < NP; p++) begin
            if (port_done[p] && exp_q[p].size() == 0) begin
               $display("port %0d pulsed done with no lookup in flight at %0t", p, $time);
               errors++;
            end else if (port_done[p]) begin
               e = exp_q[p].pop_front();
               m_ex_hit = m_ex_hit + e.ex_hit;
               m_ex_miss = m_ex_miss + !e.ex_hit;
               m_wc_hit = m_wc_hit + e.wc_hit;
               m_wc_miss = m_wc_miss + !e.wc_hit;
               m_drop[p] = m_drop[p] + (!e.ex_hit && !e.wc_hit);
               assert (action_out == e.action) else note_error($sformatf(
                  "port %0d action_out %h, expected %h", p, action_out, e.action));
            end
         end
         if (port_done == '0) begin
            assert (action_out == '0)
               else note_error($sformatf("action_out %h without a done", action_out));
         end
         assert (exact_hit == m_ex_hit && exact_miss == m_ex_miss &&
                 wildcard_hit == m_wc_hit && wildcard_miss == m_wc_miss)
            else note_error("hit or miss counter differs from the expected count");
         for (int p = 0; p < NP; p++) begin
            assert (port_dropped[p] == m_drop[p]) else note_error($sformatf(
               "port_dropped[%0d] is %0d, expected %0d", p, port_dropped[p], m_drop[p]));
         end
      end
   end

   // ----------------------------------------
   // test sequence
   // ----------------------------------------
   initial begin : main
      flow_pkg::match_t wc_base;
      int mark;
      aresetn = 1'b0;
      port_req = '0;
      for (int p = 0; p < NP; p++) begin
         port_match[p] = '0;
         m_drop[p] = '0;
      end
      host_req = 1'b0;
      host_wc = 1'b0;
      host_addr = '0;
      host_match = '0;
      host_mask = '0;
      host_action = '0;
      ex_valid = '0;
      wc_valid = '0;
      m_ex_hit = '0;
      m_ex_miss = '0;
      m_wc_hit = '0;
      m_wc_miss = '0;
      repeat (RESET_CYCLES) @(negedge asclk);
      aresetn = 1'b1;
      @(negedge asclk);

      mark = errors;
      assert (port_ack == '0 && !host_ack && port_done == '0 && !host_done)
         else note_error("ack or done high after reset");
      assert (action_out == '0) else note_error("action_out nonzero after reset");
      assert (exact_hit == '0 && exact_miss == '0 && wildcard_hit == '0 && wildcard_miss == '0)
         else note_error("counter nonzero after reset");
      finish_test("reset", mark);

      // exact keys, the second one sits at its idx1
      mark = errors;
      wc_base = random_key();
      key_set[0] = random_key();
      do begin
         key_set[1] = random_key();
      end while (fold_bytes(key_set[1], 1'b0) == fold_bytes(key_set[1], 1'b1) ||
                 fold_bytes(key_set[1], 1'b1) == fold_bytes(key_set[0], 1'b0));
      do begin
         key_set[2] = {wc_base[63:32], $random(seed)};
      end while (fold_bytes(key_set[2], 1'b0) == fold_bytes(key_set[0], 1'b0) ||
                 fold_bytes(key_set[2], 1'b0) == fold_bytes(key_set[1], 1'b1));
      key_set[3] = {wc_base[63:32], $random(seed)};
      key_set[4] = {wc_base[63:48], ~wc_base[47:32], $random(seed)};
      key_set[5] = {~wc_base[63:48], 16'($random(seed)), $random(seed)};
      key_set[6] = {~wc_base[63:48], 16'($random(seed)), $random(seed)};
      key_set[7] = random_key();
      host_write(1'b0, fold_bytes(key_set[0], 1'b0), key_set[0], '0, 32'h0000_0a01);
      host_write(1'b0, fold_bytes(key_set[1], 1'b1), key_set[1], '0, 32'h0000_0b02);
      host_write(1'b0, fold_bytes(key_set[2], 1'b0), key_set[2], '0, 32'h0000_0c03);
      // entry 2 lies inside entry 5
      host_write(1'b1, 8'd2, wc_base, 64'h0000_0000_ffff_ffff, 32'h0000_0d04);
      host_write(1'b1, 8'd5, wc_base, 64'h0000_ffff_ffff_ffff, 32'h0000_0e05);
      finish_test("host writes", mark);

      mark = errors;
      lookup(0, key_set[0]);
      lookup(1, key_set[1]);
      finish_test("exact hit", mark);

      mark = errors;
      lookup(2, key_set[3]);
      lookup(3, key_set[4]);
      lookup(0, key_set[2]);
      finish_test("wildcard hit", mark);

      mark = errors;
      lookup(1, key_set[5]);
      lookup(3, key_set[6]);
      finish_test("miss", mark);

      mark = errors;
      fork
         lookup_burst(0, BURST);
         lookup_burst(1, BURST);
         lookup_burst(2, BURST);
         lookup_burst(3, BURST);
         host_rewrite_burst(BURST);
      join
      do @(negedge asclk); while (work_pending());
      finish_test("arbitration", mark);

      $display("tests %0d, failed %0d, errors %0d, assertion failures %0d",
               tests, failed_tests, errors, u_flow_table_ctrl.u_props.fail_count);
      if (errors == 0 && u_flow_table_ctrl.u_props.fail_count == 0) begin
         $display("=== PASS ===");
      end else begin
         $display("=== FAIL ===");
      end
      $finish;
   end

endmodule

// File: src/action_select.sv
/* final action, done pulses and counters, one cycle
   host items pulse host_done only and leave the counters alone */
`timescale 1ns/1ns
`include "flow_defs.svh"

module action_select (
   input logic asclk,
   input logic aresetn,
   input flow_pkg::lookup_res_t res,
   input logic ex_hit,
   input flow_pkg::action_t ex_action,
   output flow_pkg::action_t action_out,
   output logic [`FLOW_NUM_PORTS-1:0] port_done,
   output logic host_done,
   output flow_pkg::cnt_t exact_hit,
   output flow_pkg::cnt_t exact_miss,
   output flow_pkg::cnt_t wildcard_hit,
   output flow_pkg::cnt_t wildcard_miss,
   output flow_pkg::cnt_t port_dropped [`FLOW_NUM_PORTS]
);

   localparam int PW = $clog2(`FLOW_NUM_PORTS);

   flow_pkg::lookup_res_t lres;
   flow_pkg::action_t act_d;
   logic pkt;

   // full result of both tables
   always_comb begin
      lres = res;
      lres.ex_hit = ex_hit;
      lres.ex_action = ex_action;
   end

   assign pkt = lres.valid & ~lres.is_host;

   // exact before wildcard, else drop
   always_comb begin
      if (lres.ex_hit) begin
         act_d = lres.ex_action;
      end else if (lres.wc_hit) begin
         act_d = lres.wc_action;
      end else begin
         act_d = '0;
      end
   end

   // ----------------------------------------
   // outputs and counters
   // ----------------------------------------
   always_ff @(posedge asclk) begin
      if (!aresetn) begin
         action_out <= '0;
         port_done <= '0;
         host_done <= 1'b0;
         exact_hit <= '0;
         exact_miss <= '0;
         wildcard_hit <= '0;
         wildcard_miss <= '0;
         for (int p = 0; p < `FLOW_NUM_PORTS; p++) begin
            port_dropped[p] <= '0;
         end
      end else begin
         action_out <= pkt ? act_d : '0;
         port_done <= '0;
         host_done <= lres.valid & lres.is_host;
         if (pkt) begin
            port_done[lres.src[PW-1:0]] <= 1'b1;
            if (lres.ex_hit) begin
               exact_hit <= exact_hit + 1'b1;
            end else begin
               exact_miss <= exact_miss + 1'b1;
            end
            if (lres.wc_hit) begin
               wildcard_hit <= wildcard_hit + 1'b1;
            end else begin
               wildcard_miss <= wildcard_miss + 1'b1;
            end
            if (!lres.ex_hit && !lres.wc_hit) begin
               port_dropped[lres.src[PW-1:0]] <= port_dropped[lres.src[PW-1:0]] + 1'b1;
            end
         end
      end
   end

endmodule

// File: src/exact_table.sv
/* exact-match store, registered read then compare, two cycles
   a host item writes at host_addr instead of reading */
`timescale 1ns/1ns
`include "flow_defs.svh"

module exact_table (
   input logic asclk,
   input logic aresetn,
   input flow_pkg::hash_item_t hash_item,
   output logic ex_hit,
   output flow_pkg::action_t ex_action
);

   localparam int DEPTH = 1 << `FLOW_EX_IDX_W;

   flow_pkg::match_t key_mem [DEPTH];
   flow_pkg::action_t act_mem [DEPTH];
   logic [DEPTH-1:0] ent_valid;

   logic host_wr;
   logic lookup_q;
   logic v0_q;
   logic v1_q;
   logic hit0;
   logic hit1;
   flow_pkg::match_t key0_q;
   flow_pkg::match_t key1_q;
   flow_pkg::match_t match_q;
   flow_pkg::action_t act0_q;
   flow_pkg::action_t act1_q;

   assign host_wr = hash_item.req.valid & hash_item.req.is_host & ~hash_item.req.host_wc;

   // ----------------------------------------
   // read step
   // ----------------------------------------
   always_ff @(posedge asclk) begin
      if (host_wr) begin
         key_mem[hash_item.req.host_addr] <= hash_item.req.match;
         act_mem[hash_item.req.host_addr] <= hash_item.req.action;
      end
      key0_q <= key_mem[hash_item.idx0];
      key1_q <= key_mem[hash_item.idx1];
      act0_q <= act_mem[hash_item.idx0];
      act1_q <= act_mem[hash_item.idx1];
      v0_q <= ent_valid[hash_item.idx0];
      v1_q <= ent_valid[hash_item.idx1];
      match_q <= hash_item.req.match;
      // idx0 wins when both candidates hit
      ex_action <= hit0 ? act0_q : act1_q;
   end

   // ----------------------------------------
   // compare step
   // ----------------------------------------
   assign hit0 = v0_q && (key0_q == match_q);
   assign hit1 = v1_q && (key1_q == match_q);

   always_ff @(posedge asclk) begin
      if (!aresetn) begin
         ent_valid <= '0;
         lookup_q <= 1'b0;
         ex_hit <= 1'b0;
      end else begin
         if (host_wr) begin
            ent_valid[hash_item.req.host_addr] <= 1'b1;
         end
         // host items never report a hit
         lookup_q <= hash_item.req.valid & ~hash_item.req.is_host;
         ex_hit <= lookup_q & (hit0 | hit1);
      end
   end

endmodule

// File: src/flow_arbiter.sv
/* round-robin over four ports and the host, one grant per clock
   a requester acked in the previous cycle is skipped */
`timescale 1ns/1ns
`include "flow_defs.svh"

module flow_arbiter (
   input logic asclk,
   input logic aresetn,
   input logic [`FLOW_NUM_PORTS-1:0] port_req,
   input flow_pkg::match_t port_match [`FLOW_NUM_PORTS],
   input logic host_req,
   input logic host_wc,
   input flow_pkg::ex_idx_t host_addr,
   input flow_pkg::match_t host_match,
   input flow_pkg::match_t host_mask,
   input flow_pkg::action_t host_action,
   output logic [`FLOW_NUM_PORTS-1:0] port_ack,
   output logic host_ack,
   output flow_pkg::req_item_t req_item
);

   localparam int NUM_REQ = `FLOW_NUM_PORTS + 1;
   localparam int PW = $clog2(`FLOW_NUM_PORTS);

   flow_pkg::src_t rr_cnt;
   flow_pkg::src_t sel;
   logic [NUM_REQ-1:0] req_all;
   logic [NUM_REQ-1:0] grant_d;
   logic [NUM_REQ-1:0] grant_q;
   flow_pkg::req_item_t item_d;

   // requester at offset k from the counter, wrapped
   function automatic flow_pkg::src_t rr_index(flow_pkg::src_t base, int k);
      int sum;
      sum = int'(base) + k;
      if (sum >= NUM_REQ) begin
         sum = sum - NUM_REQ;
      end
      return flow_pkg::src_t'(sum);
   endfunction

   assign req_all = {host_req, port_req};

   // ----------------------------------------
   // grant select
   // ----------------------------------------
   // walk from the far end so the nearest offset wins
   always_comb begin
      flow_pkg::src_t idx;
      grant_d = '0;
      sel = '0;
      for (int k = NUM_REQ - 1; k >= 0; k--) begin
         idx = rr_index(rr_cnt, k);
         if (req_all[idx] && !grant_q[idx]) begin
            grant_d = '0;
            grant_d[idx] = 1'b1;
            sel = idx;
         end
      end
   end

   // fields of the granted request
   always_comb begin
      item_d = '0;
      item_d.valid = |grant_d;
      item_d.src = sel;
      item_d.is_host = grant_d[NUM_REQ-1];
      if (grant_d[NUM_REQ-1]) begin
         item_d.host_wc = host_wc;
         item_d.host_addr = host_addr;
         item_d.match = host_match;
         item_d.mask = host_mask;
         item_d.action = host_action;
      end else begin
         item_d.match = port_match[sel[PW-1:0]];
      end
   end

   always_ff @(posedge asclk) begin
      if (!aresetn) begin
         rr_cnt <= '0;
         grant_q <= '0;
         req_item.valid <= 1'b0;
      end else begin
         rr_cnt <= (rr_cnt == flow_pkg::src_t'(NUM_REQ - 1)) ? '0 : rr_cnt + 1'b1;
         grant_q <= grant_d;
         req_item <= item_d;
      end
   end

   assign port_ack = grant_q[NUM_REQ-2:0];
   assign host_ack = grant_q[NUM_REQ-1];

endmodule

// File: src/flow_hash.sv
/* two exact-table candidates per key, one cycle
   idx1 rotates byte k left by k bits before the XOR */
`timescale 1ns/1ns
`include "flow_defs.svh"

module flow_hash (
   input logic asclk,
   input logic aresetn,
   input flow_pkg::req_item_t req_item,
   output flow_pkg::hash_item_t hash_item
);

   localparam int NUM_BYTES = `FLOW_MATCH_W / 8;

   flow_pkg::ex_idx_t h0;
   flow_pkg::ex_idx_t h1;

   function automatic logic [7:0] rotl8(logic [7:0] b, int k);
      logic [15:0] t;
      t = {b, b} << k;
      return t[15:8];
   endfunction

   // ----------------------------------------
   // byte folding
   // ----------------------------------------
   always_comb begin
      h0 = '0;
      h1 = '0;
      for (int k = 0; k < NUM_BYTES; k++) begin
         h0 = h0 ^ req_item.match[8*k +: 8];
         h1 = h1 ^ rotl8(req_item.match[8*k +: 8], k % 8);
      end
   end

   always_ff @(posedge asclk) begin
      if (!aresetn) begin
         hash_item.req.valid <= 1'b0;
      end else begin
         hash_item.req <= req_item;
         hash_item.idx0 <= h0;
         hash_item.idx1 <= h1;
      end
   end

endmodule

// File: src/flow_pkg.sv
/* shared types of the flow table pipeline
   an action of zero means drop */
`include "flow_defs.svh"

package flow_pkg;

   // ----------------------------------------
   // plain vectors
   // ----------------------------------------
   typedef logic [`FLOW_MATCH_W-1:0] match_t;
   typedef logic [`FLOW_ACTION_W-1:0] action_t;
   typedef logic [`FLOW_EX_IDX_W-1:0] ex_idx_t;
   typedef logic [`FLOW_WC_IDX_W-1:0] wc_idx_t;
   // 0..3 are lookup ports, 4 is the host
   typedef logic [2:0] src_t;
   typedef logic [`FLOW_CNT_W-1:0] cnt_t;

   // ----------------------------------------
   // pipeline items
   // ----------------------------------------
   // granted request, as captured by the arbiter
   typedef struct packed {
      logic valid;
      src_t src;
      logic is_host;
      logic host_wc;
      ex_idx_t host_addr;
      match_t match;
      match_t mask;
      action_t action;
   } req_item_t;

   // request plus both exact candidates
   typedef struct packed {
      req_item_t req;
      ex_idx_t idx0;
      ex_idx_t idx1;
   } hash_item_t;

   // result of both tables for one item
   typedef struct packed {
      logic valid;
      src_t src;
      logic is_host;
      logic ex_hit;
      action_t ex_action;
      logic wc_hit;
      action_t wc_action;
   } lookup_res_t;

endpackage

// File: src/flow_table_ctrl.sv
/* flow table lookup controller, done follows ack by 4 cycles
   no back-pressure, requesters wait only for the arbiter */
`timescale 1ns/1ns
`include "flow_defs.svh"

module flow_table_ctrl (
   input logic asclk,
   input logic aresetn,
   // lookup ports
   input logic [`FLOW_NUM_PORTS-1:0] port_req,
   input flow_pkg::match_t port_match [`FLOW_NUM_PORTS],
   output logic [`FLOW_NUM_PORTS-1:0] port_ack,
   output logic [`FLOW_NUM_PORTS-1:0] port_done,
   output flow_pkg::action_t action_out,
   // host writes
   input logic host_req,
   input logic host_wc,
   input flow_pkg::ex_idx_t host_addr,
   input flow_pkg::match_t host_match,
   input flow_pkg::match_t host_mask,
   input flow_pkg::action_t host_action,
   output logic host_ack,
   output logic host_done,
   // counters
   output flow_pkg::cnt_t exact_hit,
   output flow_pkg::cnt_t exact_miss,
   output flow_pkg::cnt_t wildcard_hit,
   output flow_pkg::cnt_t wildcard_miss,
   output flow_pkg::cnt_t port_dropped [`FLOW_NUM_PORTS]
);

   flow_pkg::req_item_t req_item;
   flow_pkg::hash_item_t hash_item;
   flow_pkg::lookup_res_t res;
   logic ex_hit;
   flow_pkg::action_t ex_action;

   // ----------------------------------------
   // pipeline
   // ----------------------------------------
   flow_arbiter u_arbiter (
      .asclk(asclk),
      .aresetn(aresetn),
      .port_req(port_req),
      .port_match(port_match),
      .host_req(host_req),
      .host_wc(host_wc),
      .host_addr(host_addr),
      .host_match(host_match),
      .host_mask(host_mask),
      .host_action(host_action),
      .port_ack(port_ack),
      .host_ack(host_ack),
      .req_item(req_item)
   );

   flow_hash u_hash (
      .asclk(asclk),
      .aresetn(aresetn),
      .req_item(req_item),
      .hash_item(hash_item)
   );

   exact_table u_exact (
      .asclk(asclk),
      .aresetn(aresetn),
      .hash_item(hash_item),
      .ex_hit(ex_hit),
      .ex_action(ex_action)
   );

   // wildcard compare runs in parallel with the hash
   wildcard_table u_wildcard (
      .asclk(asclk),
      .aresetn(aresetn),
      .req_item(req_item),
      .hash_item(hash_item),
      .res(res)
   );

   action_select u_select (
      .asclk(asclk),
      .aresetn(aresetn),
      .res(res),
      .ex_hit(ex_hit),
      .ex_action(ex_action),
      .action_out(action_out),
      .port_done(port_done),
      .host_done(host_done),
      .exact_hit(exact_hit),
      .exact_miss(exact_miss),
      .wildcard_hit(wildcard_hit),
      .wildcard_miss(wildcard_miss),
      .port_dropped(port_dropped)
   );

endmodule

// File: src/wildcard_table.sv
/* masked match store beside the hash and exact stages
   mask bit 1 is don't-care, lowest matching index wins */
`timescale 1ns/1ns
`include "flow_defs.svh"

module wildcard_table (
   input logic asclk,
   input logic aresetn,
   input flow_pkg::req_item_t req_item,
   input flow_pkg::hash_item_t hash_item,
   output flow_pkg::lookup_res_t res
);

   localparam int DEPTH = `FLOW_WC_DEPTH;

   flow_pkg::match_t wc_key [DEPTH];
   flow_pkg::match_t wc_mask [DEPTH];
   flow_pkg::action_t wc_act [DEPTH];
   logic [DEPTH-1:0] wc_valid;

   logic [DEPTH-1:0] hit_vec;
   logic [DEPTH-1:0] hit_vec_q;
   logic any_hit;
   flow_pkg::wc_idx_t enc_idx;
   logic host_wr;

   logic s2_valid;
   logic s2_hit;
   logic s2_is_host;
   flow_pkg::src_t s2_src;
   flow_pkg::wc_idx_t s2_idx;

   // ----------------------------------------
   // compare, same cycle as the hash
   // ----------------------------------------
   always_comb begin
      for (int i = 0; i < DEPTH; i++) begin
         hit_vec[i] = wc_valid[i] &&
                      (((req_item.match ^ wc_key[i]) & ~wc_mask[i]) == '0);
      end
   end

   // priority encoder, lowest index last so it wins
   always_comb begin
      any_hit = |hit_vec_q;
      enc_idx = '0;
      for (int i = DEPTH - 1; i >= 0; i--) begin
         if (hit_vec_q[i]) begin
            enc_idx = flow_pkg::wc_idx_t'(i);
         end
      end
   end

   assign host_wr = hash_item.req.valid & hash_item.req.is_host & hash_item.req.host_wc;

   // entry store and action read
   always_ff @(posedge asclk) begin
      hit_vec_q <= hit_vec;
      if (host_wr) begin
         wc_key[hash_item.req.host_addr[`FLOW_WC_IDX_W-1:0]] <= hash_item.req.match;
         wc_mask[hash_item.req.host_addr[`FLOW_WC_IDX_W-1:0]] <= hash_item.req.mask;
         wc_act[hash_item.req.host_addr[`FLOW_WC_IDX_W-1:0]] <= hash_item.req.action;
      end
      s2_idx <= enc_idx;
      s2_src <= hash_item.req.src;
      s2_is_host <= hash_item.req.is_host;
   end

   // ----------------------------------------
   // alignment with the exact compare
   // ----------------------------------------
   always_ff @(posedge asclk) begin
      if (!aresetn) begin
         wc_valid <= '0;
         s2_valid <= 1'b0;
         s2_hit <= 1'b0;
         res.valid <= 1'b0;
         res.wc_hit <= 1'b0;
      end else begin
         if (host_wr) begin
            wc_valid[hash_item.req.host_addr[`FLOW_WC_IDX_W-1:0]] <= 1'b1;
         end
         s2_valid <= hash_item.req.valid;
         s2_hit <= hash_item.req.valid & ~hash_item.req.is_host & any_hit;
         res.valid <= s2_valid;
         res.src <= s2_src;
         res.is_host <= s2_is_host;
         res.wc_hit <= s2_hit;
         res.wc_action <= wc_act[s2_idx];
         // exact fields are merged in action_select
         res.ex_hit <= 1'b0;
         res.ex_action <= '0;
      end
   end

endmodule
